// ==== common/tcb_pkg.sv ====
package tcb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////////////////////

  // address and data width
  localparam int unsigned AW = 32;
  localparam int unsigned DW = 32;
  // bytes per data word
  localparam int unsigned BW = DW / 8;
  // bits per byte lane
  localparam int unsigned SW = DW / BW;

  // address split, region code on top
  localparam int unsigned RW = 4;
  // word offset inside a region, byte lane included
  localparam int unsigned OW = AW - RW;

  ////////////////////////////////////////////////////////////////////////////
  // bus types
  ////////////////////////////////////////////////////////////////////////////

  // one data word, read or write
  typedef logic [DW-1:0] data_t;

  // one bit per byte lane
  typedef logic [BW-1:0] ben_t;

  // address as seen by the target decoder
  typedef struct packed {
    // selects sram, id word or unmapped space
    logic [RW-1:0] region;
    // low 2 bits are the byte lane
    logic [OW-1:0] offset;
  } adr_fields_t;

  // same 32 bits, two views
  // flat for arbiter and slice, fields for the memory decoder
  typedef union packed {
    logic [AW-1:0] flat;
    adr_fields_t   fields;
  } adr_t;

endpackage

// ==== common/mem_map_pkg.sv ====
package mem_map_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // region codes
  ////////////////////////////////////////////////////////////////////////////

  // byte addressable sram
  localparam logic [tcb_pkg::RW-1:0] REGION_SRAM = 4'd0;

  // read only identification word
  localparam logic [tcb_pkg::RW-1:0] REGION_ID = 4'd1;

  // every other region code is unmapped, answered with err

  ////////////////////////////////////////////////////////////////////////////
  // constants
  ////////////////////////////////////////////////////////////////////////////

  // value returned by a read of the id region
  localparam tcb_pkg::data_t ID_VALUE = 32'h7cb5_0001;

  // sram size in words when the top level leaves it alone
  localparam int unsigned MEM_DEPTH_DEFAULT = 256;

endpackage

// ==== hw/tcb_arbiter.sv ====
`timescale 1ns/1ns

module tcb_arbiter (
  input  logic           sub,
  input  logic           reset,
  // manager 0 request
  input  logic           m0_vld,
  input  logic           m0_wen,
  input  tcb_pkg::ben_t  m0_ben,
  input  tcb_pkg::adr_t  m0_adr,
  input  tcb_pkg::data_t m0_wdt,
  // manager 0 ready and response
  output logic           m0_rdy,
  output tcb_pkg::data_t m0_rdt,
  output logic           m0_err,
  // manager 1 request
  input  logic           m1_vld,
  input  logic           m1_wen,
  input  tcb_pkg::ben_t  m1_ben,
  input  tcb_pkg::adr_t  m1_adr,
  input  tcb_pkg::data_t m1_wdt,
  // manager 1 ready and response
  output logic           m1_rdy,
  output tcb_pkg::data_t m1_rdt,
  output logic           m1_err,
  // shared bus toward the register slice
  output logic           arb_vld,
  output logic           arb_wen,
  output tcb_pkg::ben_t  arb_ben,
  output tcb_pkg::adr_t  arb_adr,
  output tcb_pkg::data_t arb_wdt,
  input  logic           arb_rdy,
  input  tcb_pkg::data_t arb_rdt,
  input  logic           arb_err
);

  ////////////////////////////////////////////////////////////////////////////
  // grant
  ////////////////////////////////////////////////////////////////////////////

  // priority pointer, low favours m0, high favours m1
  logic pri;
  // one hot grant, both low when idle
  logic gnt0;
  logic gnt1;
  // request accepted this cycle
  logic xfr;
  // the accepted request came from the favoured manager
  logic xfr_fav;

  // m0 wins when alone or when favoured
  assign gnt0 = m0_vld & (~m1_vld | ~pri);
  // m1 wins when alone or when favoured
  assign gnt1 = m1_vld & (~m0_vld | pri);

  assign xfr = arb_vld & arb_rdy;
  assign xfr_fav = pri ? gnt1 : gnt0;

  // pointer moves away from the favoured manager once it has been served
  // so the loser of a tie wins on the very next cycle
  always_ff @(posedge sub) begin
    if (reset) begin
      pri <= 1'b0;
    end else if (xfr & xfr_fav) begin
      pri <= ~pri;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // request multiplexer
  ////////////////////////////////////////////////////////////////////////////

  // any manager asking is enough to drive the shared bus
  assign arb_vld = m0_vld | m1_vld;

  // payload follows the grant
  // m0 fields sit on the bus when nothing is requested
  always_comb begin
    if (gnt1) begin
      arb_wen      = m1_wen;
      arb_ben      = m1_ben;
      arb_adr.flat = m1_adr.flat;
      arb_wdt      = m1_wdt;
    end else begin
      arb_wen      = m0_wen;
      arb_ben      = m0_ben;
      arb_adr.flat = m0_adr.flat;
      arb_wdt      = m0_wdt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // ready and response
  ////////////////////////////////////////////////////////////////////////////

  // losing manager sees rdy low and holds its request
  assign m0_rdy = gnt0 & arb_rdy;
  assign m1_rdy = gnt1 & arb_rdy;

  // response has no strobe, both managers see it
  // each one picks the beat that lands DLY cycles after its own transfer
  assign m0_rdt = arb_rdt;
  assign m0_err = arb_err;
  assign m1_rdt = arb_rdt;
  assign m1_err = arb_err;

endmodule

// ==== tcb_reg/tcb_reg.sv ====
`timescale 1ns/1ns

module tcb_reg #(
  // register the request path
  parameter bit CFG_REQ_REG = 1'b1,
  // register the response path
  parameter bit CFG_RSP_REG = 1'b1
)(
  input  logic           sub,
  input  logic           reset,
  // subordinate port, arbiter side
  input  logic           sub_vld,
  input  logic           sub_wen,
  input  tcb_pkg::ben_t  sub_ben,
  input  tcb_pkg::adr_t  sub_adr,
  input  tcb_pkg::data_t sub_wdt,
  output logic           sub_rdy,
  output tcb_pkg::data_t sub_rdt,
  output logic           sub_err,
  // manager port, memory side
  output logic           man_vld,
  output logic           man_wen,
  output tcb_pkg::ben_t  man_ben,
  output tcb_pkg::adr_t  man_adr,
  output tcb_pkg::data_t man_wdt,
  input  logic           man_rdy,
  input  tcb_pkg::data_t man_rdt,
  input  logic           man_err
);

  ////////////////////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////////////////////

  if (CFG_REQ_REG) begin : gen_req_reg
    // only the strobe needs a known value out of reset
    always_ff @(posedge sub) begin
      if (reset) begin
        man_vld <= 1'b0;
      end else begin
        man_vld <= sub_vld;
      end
    end
    // payload flops, meaningful only next to vld
    always_ff @(posedge sub) begin
      man_wen      <= sub_wen;
      man_ben      <= sub_ben;
      man_adr.flat <= sub_adr.flat;
      man_wdt      <= sub_wdt;
    end
  end else begin : gen_req_cmb
    assign man_vld      = sub_vld;
    assign man_wen      = sub_wen;
    assign man_ben      = sub_ben;
    assign man_adr.flat = sub_adr.flat;
    assign man_wdt      = sub_wdt;
  end

  ////////////////////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////////////////////

  if (CFG_RSP_REG) begin : gen_rsp_reg
    // one extra cycle of response delay
    always_ff @(posedge sub) begin
      sub_rdt <= man_rdt;
      sub_err <= man_err;
    end
  end else begin : gen_rsp_cmb
    assign sub_rdt = man_rdt;
    assign sub_err = man_err;
  end

  // memory never stalls, rdy is a straight wire either way
  assign sub_rdy = man_rdy;

endmodule

// ==== tcb_mem/tcb_mem.sv ====
`timescale 1ns/1ns

module tcb_mem #(
  // sram size in words
  parameter int unsigned MEM_DEPTH = mem_map_pkg::MEM_DEPTH_DEFAULT
)(
  input  logic           sub,
  input  logic           reset,
  // request
  input  logic           vld,
  input  logic           wen,
  input  tcb_pkg::ben_t  ben,
  input  tcb_pkg::adr_t  adr,
  input  tcb_pkg::data_t wdt,
  // ready and response
  output logic           rdy,
  output tcb_pkg::data_t rdt,
  output logic           err
);

  // index width, at least one bit
  localparam int unsigned IW = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  // word address, byte lane dropped
  logic [tcb_pkg::OW-3:0] word;
  // word address folded into the array
  logic [IW-1:0] idx;
  // region hits
  logic hit_sram;
  logic hit_id;
  // access answered with err
  logic fail;

  assign word = adr.fields.offset[tcb_pkg::OW-1:2];
  // wraps modulo depth, also for depths that are not a power of two
  assign idx = IW'(word % MEM_DEPTH);

  assign hit_sram = (adr.fields.region == mem_map_pkg::REGION_SRAM);
  assign hit_id   = (adr.fields.region == mem_map_pkg::REGION_ID);

  // id word is read only, anything outside both regions is unmapped
  assign fail = hit_id ? wen : ~hit_sram;

  ////////////////////////////////////////////////////////////////////////////
  // sram array
  ////////////////////////////////////////////////////////////////////////////

  tcb_pkg::data_t mem [MEM_DEPTH];

  // write lands at the transfer edge, enabled lanes only
  always_ff @(posedge sub) begin
    if (vld & wen & hit_sram) begin
      for (int i = 0; i < tcb_pkg::BW; i++) begin
        if (ben[i]) begin
          mem[idx][tcb_pkg::SW*i +: tcb_pkg::SW] <= wdt[tcb_pkg::SW*i +: tcb_pkg::SW];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  // read data one cycle after the transfer
  // held between transfers
  always_ff @(posedge sub) begin
    if (vld) begin
      if (hit_sram) begin
        rdt <= mem[idx];
      end else if (hit_id) begin
        rdt <= mem_map_pkg::ID_VALUE;
      end else begin
        // unmapped reads return zero
        rdt <= '0;
      end
    end
  end

  // err is a pulse aligned with rdt
  always_ff @(posedge sub) begin
    if (reset) begin
      err <= 1'b0;
    end else begin
      err <= vld & fail;
    end
  end

  // single cycle target, never back-pressures
  assign rdy = 1'b1;

endmodule

// ==== hw/tcb_sys.sv ====
`timescale 1ns/1ns

module tcb_sys #(
  // register slice setup, DLY = 1 + CFG_REQ_REG + CFG_RSP_REG
  parameter bit          CFG_REQ_REG = 1'b1,
  parameter bit          CFG_RSP_REG = 1'b1,
  // sram size in words
  parameter int unsigned MEM_DEPTH   = mem_map_pkg::MEM_DEPTH_DEFAULT
)(
  input  logic           sub,
  input  logic           reset,
  // manager 0
  input  logic           m0_vld,
  input  logic           m0_wen,
  input  tcb_pkg::ben_t  m0_ben,
  input  tcb_pkg::adr_t  m0_adr,
  input  tcb_pkg::data_t m0_wdt,
  output logic           m0_rdy,
  output tcb_pkg::data_t m0_rdt,
  output logic           m0_err,
  // manager 1
  input  logic           m1_vld,
  input  logic           m1_wen,
  input  tcb_pkg::ben_t  m1_ben,
  input  tcb_pkg::adr_t  m1_adr,
  input  tcb_pkg::data_t m1_wdt,
  output logic           m1_rdy,
  output tcb_pkg::data_t m1_rdt,
  output logic           m1_err
);

  ////////////////////////////////////////////////////////////////////////////
  // internal buses
  ////////////////////////////////////////////////////////////////////////////

  // arbiter to slice
  logic           arb_vld;
  logic           arb_wen;
  tcb_pkg::ben_t  arb_ben;
  tcb_pkg::adr_t  arb_adr;
  tcb_pkg::data_t arb_wdt;
  // slice back to arbiter
  logic           arb_rdy;
  tcb_pkg::data_t arb_rdt;
  logic           arb_err;

  // slice to memory
  logic           mem_vld;
  logic           mem_wen;
  tcb_pkg::ben_t  mem_ben;
  tcb_pkg::adr_t  mem_adr;
  tcb_pkg::data_t mem_wdt;
  // memory back to slice
  logic           mem_rdy;
  tcb_pkg::data_t mem_rdt;
  logic           mem_err;

  ////////////////////////////////////////////////////////////////////////////
  // instances
  ////////////////////////////////////////////////////////////////////////////

  // round robin between the two managers
  tcb_arbiter arb_i (
    .sub     (sub),
    .reset   (reset),
    .m0_vld  (m0_vld),
    .m0_wen  (m0_wen),
    .m0_ben  (m0_ben),
    .m0_adr  (m0_adr),
    .m0_wdt  (m0_wdt),
    .m0_rdy  (m0_rdy),
    .m0_rdt  (m0_rdt),
    .m0_err  (m0_err),
    .m1_vld  (m1_vld),
    .m1_wen  (m1_wen),
    .m1_ben  (m1_ben),
    .m1_adr  (m1_adr),
    .m1_wdt  (m1_wdt),
    .m1_rdy  (m1_rdy),
    .m1_rdt  (m1_rdt),
    .m1_err  (m1_err),
    .arb_vld (arb_vld),
    .arb_wen (arb_wen),
    .arb_ben (arb_ben),
    .arb_adr (arb_adr),
    .arb_wdt (arb_wdt),
    .arb_rdy (arb_rdy),
    .arb_rdt (arb_rdt),
    .arb_err (arb_err)
  );

  // request and response register stages
  tcb_reg #(
    .CFG_REQ_REG (CFG_REQ_REG),
    .CFG_RSP_REG (CFG_RSP_REG)
  ) reg_i (
    .sub     (sub),
    .reset   (reset),
    .sub_vld (arb_vld),
    .sub_wen (arb_wen),
    .sub_ben (arb_ben),
    .sub_adr (arb_adr),
    .sub_wdt (arb_wdt),
    .sub_rdy (arb_rdy),
    .sub_rdt (arb_rdt),
    .sub_err (arb_err),
    .man_vld (mem_vld),
    .man_wen (mem_wen),
    .man_ben (mem_ben),
    .man_adr (mem_adr),
    .man_wdt (mem_wdt),
    .man_rdy (mem_rdy),
    .man_rdt (mem_rdt),
    .man_err (mem_err)
  );

  // sram and id word target
  tcb_mem #(
    .MEM_DEPTH (MEM_DEPTH)
  ) mem_i (
    .sub   (sub),
    .reset (reset),
    .vld   (mem_vld),
    .wen   (mem_wen),
    .ben   (mem_ben),
    .adr   (mem_adr),
    .wdt   (mem_wdt),
    .rdy   (mem_rdy),
    .rdt   (mem_rdt),
    .err   (mem_err)
  );

endmodule

// ==== tests/tcb_sys_tb.sv ====
`timescale 1ns/1ns

module tcb_sys_tb;

  ////////////////////////////////////////////////////////////////////////////
  // setup
  ////////////////////////////////////////////////////////////////////////////

  localparam bit CFG_REQ_REG = 1'b1;
  localparam bit CFG_RSP_REG = 1'b1;
  localparam int DEPTH = 256;
  // response delay seen by a manager
  localparam int DLY = 1 + CFG_REQ_REG + CFG_RSP_REG;
  localparam int PERIOD = 20;
  localparam int RESET_CYCLES = 16;
  localparam int N_PIPE = 16;
  // 2 single + 33 byte enable + 5 id + 4 contention + 32 pipeline
  localparam int N_XFER = 76;
  localparam int TIMEOUT = (N_XFER * (DLY + 4) + RESET_CYCLES) * PERIOD;

  logic sub;
  logic reset;
  logic m0_vld;
  logic m0_wen;
  logic m0_rdy;
  logic m0_err;
  logic m1_vld;
  logic m1_wen;
  logic m1_rdy;
  logic m1_err;
  tcb_pkg::ben_t  m0_ben;
  tcb_pkg::ben_t  m1_ben;
  tcb_pkg::adr_t  m0_adr;
  tcb_pkg::adr_t  m1_adr;
  tcb_pkg::data_t m0_wdt;
  tcb_pkg::data_t m1_wdt;
  tcb_pkg::data_t m0_rdt;
  tcb_pkg::data_t m1_rdt;

  integer seed = 94;
  // expected sram contents
  tcb_pkg::data_t shadow [DEPTH];
  // cycles each manager waited for rdy on its last transfer
  int last_wait [2];

  tcb_sys #(
    .CFG_REQ_REG (CFG_REQ_REG),
    .CFG_RSP_REG (CFG_RSP_REG),
    .MEM_DEPTH   (DEPTH)
  ) tcb_sys_i (
    .sub (sub), .reset (reset),
    .m0_vld (m0_vld), .m0_wen (m0_wen), .m0_ben (m0_ben), .m0_adr (m0_adr),
    .m0_wdt (m0_wdt), .m0_rdy (m0_rdy), .m0_rdt (m0_rdt), .m0_err (m0_err),
    .m1_vld (m1_vld), .m1_wen (m1_wen), .m1_ben (m1_ben), .m1_adr (m1_adr),
    .m1_wdt (m1_wdt), .m1_rdy (m1_rdy), .m1_rdt (m1_rdt), .m1_err (m1_err)
  );

  initial begin
    sub = 1'b0;
    forever #(PERIOD / 2) sub = ~sub;
  end

  // hang guard
  initial begin
    #(TIMEOUT);
    $display("watchdog expired: the run timed out before all tests finished");
    abort_run();
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input string name, input tcb_pkg::data_t exp,
                            input tcb_pkg::data_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_err(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: err expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_rdy(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: rdy expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // region in the top nibble and word index above the byte lane
  function automatic int model_index(input tcb_pkg::adr_t a);
    return int'(a.flat[27:2]) % DEPTH;
  endfunction

  function automatic bit model_err(input bit wen, input tcb_pkg::adr_t a);
    if (a.flat[31:28] == mem_map_pkg::REGION_SRAM) return 1'b0;
    if (a.flat[31:28] == mem_map_pkg::REGION_ID) return wen;
    return 1'b1;
  endfunction

  function automatic tcb_pkg::data_t model_rdt(input tcb_pkg::adr_t a);
    if (a.flat[31:28] == mem_map_pkg::REGION_SRAM) return shadow[model_index(a)];
    if (a.flat[31:28] == mem_map_pkg::REGION_ID) return mem_map_pkg::ID_VALUE;
    return '0;
  endfunction

  function automatic void model_write(input tcb_pkg::adr_t a, input tcb_pkg::ben_t ben,
                                      input tcb_pkg::data_t wdt);
    int idx;
    idx = model_index(a);
    if (a.flat[31:28] == mem_map_pkg::REGION_SRAM) begin
      for (int i = 0; i < 4; i++) begin
        if (ben[i]) shadow[idx][8*i +: 8] = wdt[8*i +: 8];
      end
    end
  endfunction

  function automatic tcb_pkg::adr_t sram_adr(input int word);
    tcb_pkg::adr_t a;
    a.flat = 32'(word) << 2;
    return a;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_request(input int mgr, input bit vld, input bit wen,
                               input tcb_pkg::ben_t ben, input tcb_pkg::adr_t adr,
                               input tcb_pkg::data_t wdt);
    if (mgr == 0) begin
      m0_vld = vld;
      m0_wen = wen;
      m0_ben = ben;
      m0_adr = adr;
      m0_wdt = wdt;
    end else begin
      m1_vld = vld;
      m1_wen = wen;
      m1_ben = ben;
      m1_adr = adr;
      m1_wdt = wdt;
    end
  endtask

  function automatic logic rdy_of(input int mgr);
    return (mgr == 0) ? m0_rdy : m1_rdy;
  endfunction

  // one transfer with the response taken DLY rising edges after it
  task automatic bus_access(input int mgr, input bit wen, input tcb_pkg::ben_t ben,
                            input tcb_pkg::adr_t adr, input tcb_pkg::data_t wdt,
                            output tcb_pkg::data_t rdt, output logic err);
    int waits;
    waits = 0;
    @(negedge sub);
    drive_request(mgr, 1'b1, wen, ben, adr, wdt);
    #1;
    // held while the other manager owns the bus
    while (rdy_of(mgr) !== 1'b1) begin
      @(negedge sub);
      #1;
      waits++;
    end
    last_wait[mgr] = waits;
    @(negedge sub);
    drive_request(mgr, 1'b0, 1'b0, '0, '0, '0);
    repeat (DLY - 1) @(negedge sub);
    rdt = (mgr == 0) ? m0_rdt : m1_rdt;
    err = (mgr == 0) ? m0_err : m1_err;
  endtask

  task automatic bus_write(input int mgr, input string name, input tcb_pkg::adr_t adr,
                           input tcb_pkg::ben_t ben, input tcb_pkg::data_t wdt);
    tcb_pkg::data_t rdt;
    logic err;
    bus_access(mgr, 1'b1, ben, adr, wdt, rdt, err);
    check_err(name, model_err(1'b1, adr), err);
    model_write(adr, ben, wdt);
  endtask

  task automatic bus_read(input int mgr, input string name, input tcb_pkg::adr_t adr);
    tcb_pkg::data_t rdt;
    logic err;
    bus_access(mgr, 1'b0, 4'h0, adr, '0, rdt, err);
    check_err(name, model_err(1'b0, adr), err);
    check_data(name, model_rdt(adr), rdt);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_single();
    #1;
    // idle bus after reset
    check_rdy("single", 1'b0, m0_rdy);
    check_rdy("single", 1'b0, m1_rdy);
    check_err("single", 1'b0, m0_err);
    bus_write(0, "single", sram_adr(3), 4'hf, tcb_pkg::data_t'($random(seed)));
    bus_read(0, "single", sram_adr(3));
  endtask

  task automatic test_byte_enables();
    bus_write(0, "byte enables", sram_adr(5), 4'hf, tcb_pkg::data_t'($random(seed)));
    for (int b = 0; b < 16; b++) begin
      bus_write(0, "byte enables", sram_adr(5), tcb_pkg::ben_t'(b),
                tcb_pkg::data_t'($random(seed)));
      bus_read(0, "byte enables", sram_adr(5));
    end
  endtask

  task automatic test_id_region();
    tcb_pkg::adr_t id_adr;
    tcb_pkg::adr_t bad_adr;
    id_adr.flat = 32'h1000_0000;
    bad_adr.flat = 32'h7000_0040;
    bus_read(0, "id region", id_adr);
    // id word is read only so a write answers err
    bus_write(0, "id region", id_adr, 4'hf, 32'hdead_beef);
    bus_read(0, "id region", id_adr);
    bus_read(0, "unmapped", bad_adr);
    bus_write(0, "unmapped", bad_adr, 4'hf, 32'h1234_5678);
  endtask

  task automatic test_contention();
    fork
      bus_write(0, "contention m0", sram_adr(20), 4'hf, 32'haaaa_0000);
      bus_write(1, "contention m1", sram_adr(21), 4'hf, 32'h0000_5555);
      // grant is one hot
      repeat (DLY + 3) begin
        @(negedge sub);
        #1;
        check_rdy("contention", 1'b0, m0_rdy & m1_rdy);
      end
    join
    if (last_wait[0] > 1 || last_wait[1] > 1) begin
      $display("contention: a manager was not accepted within two cycles");
      abort_run();
    end
    fork
      bus_read(0, "contention m0", sram_adr(20));
      bus_read(1, "contention m1", sram_adr(21));
    join
  endtask

  task automatic test_pipeline();
    tcb_pkg::adr_t adrs [N_PIPE];
    tcb_pkg::data_t exp [N_PIPE];
    int base;
    base = int'($unsigned($random(seed)) % (DEPTH - N_PIPE));
    for (int k = 0; k < N_PIPE; k++) begin
      adrs[k] = sram_adr(base + k);
      bus_write(0, "pipeline fill", adrs[k], 4'hf, tcb_pkg::data_t'($random(seed)));
    end
    for (int k = 0; k < N_PIPE; k++) exp[k] = model_rdt(adrs[k]);
    // one read per cycle with response k landing at cycle k + DLY
    for (int k = 0; k < N_PIPE + DLY; k++) begin
      @(negedge sub);
      if (k >= DLY) begin
        check_data("pipeline", exp[k-DLY], m0_rdt);
        check_err("pipeline", 1'b0, m0_err);
      end
      if (k < N_PIPE) begin
        drive_request(0, 1'b1, 1'b0, 4'h0, adrs[k], '0);
        #1;
        check_rdy("pipeline", 1'b1, m0_rdy);
      end else begin
        drive_request(0, 1'b0, 1'b0, '0, '0, '0);
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    drive_request(0, 1'b0, 1'b0, '0, '0, '0);
    drive_request(1, 1'b0, 1'b0, '0, '0, '0);
    repeat (RESET_CYCLES) @(posedge sub);
    @(negedge sub);
    reset = 1'b0;
    test_single();
    test_byte_enables();
    test_id_region();
    test_contention();
    test_pipeline();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== tcb_sys.f ====
common/tcb_pkg.sv
common/mem_map_pkg.sv
hw/tcb_arbiter.sv
tcb_reg/tcb_reg.sv
tcb_mem/tcb_mem.sv
hw/tcb_sys.sv
tests/tcb_sys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the tcb_sys testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
  --top-module tcb_sys_tb -Mdir obj_dir -f tcb_sys.f

# the output decides pass or fail
out=$(./obj_dir/Vtcb_sys_tb) || true
echo "$out"

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
